// ==== src/wisc_params.svh ====
`ifndef WISC_PARAMS_SVH
`define WISC_PARAMS_SVH

// datapath widths.
`define WORD_W     16
`define REG_NUM    8
`define WB_SEL_W   3

// data memory depth, in address bits of a word index.
`define DMEM_AW    8

// write-back source select codes.
`define WB_ALU     3'd0
`define WB_MEM     3'd1
`define WB_PC_INC  3'd2
`define WB_LBI     3'd3
`define WB_SLBI    3'd4
`define WB_SEXT    3'd5
`define WB_SET     3'd6
`define WB_RD1     3'd7

`endif

// ==== src/wisc_pkg.sv ====
`include "wisc_params.svh"

package wisc_pkg;

   typedef logic [`WORD_W-1:0]            word_t;      // data word.
   typedef logic [$clog2(`REG_NUM)-1:0]   reg_idx_t;   // register number.
   typedef logic [`WB_SEL_W-1:0]          wb_sel_t;    // write-back source code.
   typedef logic [`DMEM_AW-1:0]           mem_addr_t;  // data memory word index.

endpackage

// ==== src/data_mem.sv ====
`timescale 1ns/1ns
`include "wisc_params.svh"

module data_mem
   import wisc_pkg::*;
#(
   parameter int ADDR_W = `DMEM_AW
) (
   input  logic  clk,
   input  logic  reset,
   input  word_t addr,
   input  word_t wr_data,
   input  logic  rd_en,
   input  logic  wr_en,
   input  logic  stall_n,
   output word_t rd_data,
   output logic  align_err
);

   word_t             mem [2**ADDR_W];
   logic [ADDR_W-1:0] word_idx;
   logic              wr_ok;

   assign word_idx  = addr[ADDR_W:1];                 // byte address to word index.
   assign align_err = (rd_en | wr_en) & addr[0];      // odd byte address.
   assign wr_ok     = wr_en & stall_n & ~align_err;

   assign rd_data = mem[word_idx];                    // asynchronous read.

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_ok) begin
         mem[word_idx] <= wr_data;
      end
   end

   // a committed store must be visible at its word on the following cycle.
   a_write_lands : assert property (
      @(posedge clk) disable iff (reset)
      (wr_en && stall_n && !addr[0]) |=> (mem[$past(addr[ADDR_W:1])] == $past(wr_data))
   ) else $error("data_mem: aligned write did not reach memory");

endmodule

// ==== src/mem_wb.sv ====
`timescale 1ns/1ns

module mem_wb
   import wisc_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     stall_n,
   input  word_t    mem_rd_data_1,
   input  logic     mem_wr_en,
   input  reg_idx_t mem_wr_reg,
   input  wb_sel_t  mem_wr_sel,
   input  word_t    mem_alu_out,
   input  word_t    mem_mem_out,
   input  word_t    mem_pc_inc,
   input  word_t    mem_lbi,
   input  word_t    mem_slbi,
   input  word_t    mem_sext_imm,
   input  logic     mem_set,
   input  logic     mem_err,
   output word_t    wb_rd_data_1,
   output logic     wb_wr_en,
   output reg_idx_t wb_wr_reg,
   output wb_sel_t  wb_wr_sel,
   output word_t    wb_alu_out,
   output word_t    wb_mem_out,
   output word_t    wb_pc_inc,
   output word_t    wb_lbi,
   output word_t    wb_slbi,
   output word_t    wb_sext_imm,
   output logic     wb_set,
   output logic     wb_err
);

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_wr_en     <= 1'b0;
         wb_err       <= 1'b0;
         wb_rd_data_1 <= '0;
         wb_wr_reg    <= '0;
         wb_wr_sel    <= '0;
         wb_alu_out   <= '0;
         wb_mem_out   <= '0;
         wb_pc_inc    <= '0;
         wb_lbi       <= '0;
         wb_slbi      <= '0;
         wb_sext_imm  <= '0;
         wb_set       <= 1'b0;
      end else if (!stall_n) begin
         wb_wr_en <= 1'b0;                            // bubble, payload held.
         wb_err   <= 1'b0;
      end else begin
         wb_wr_en     <= mem_wr_en;
         wb_err       <= mem_err;
         wb_rd_data_1 <= mem_rd_data_1;
         wb_wr_reg    <= mem_wr_reg;
         wb_wr_sel    <= mem_wr_sel;
         wb_alu_out   <= mem_alu_out;
         wb_mem_out   <= mem_mem_out;
         wb_pc_inc    <= mem_pc_inc;
         wb_lbi       <= mem_lbi;
         wb_slbi      <= mem_slbi;
         wb_sext_imm  <= mem_sext_imm;
         wb_set       <= mem_set;
      end
   end

   a_stall_bubble : assert property (
      @(posedge clk) disable iff (reset)
      !stall_n |=> !wb_wr_en
   ) else $error("mem_wb: write enable survived a stall");

   // the held payload lets upstream re-present without a gap in state.
   a_stall_hold : assert property (
      @(posedge clk) disable iff (reset)
      !stall_n |=> $stable({wb_rd_data_1, wb_wr_reg, wb_wr_sel, wb_alu_out, wb_mem_out,
                            wb_pc_inc, wb_lbi, wb_slbi, wb_sext_imm, wb_set})
   ) else $error("mem_wb: payload changed across a stalled edge");

endmodule

// ==== src/wb_reg_file.sv ====
`timescale 1ns/1ns
`include "wisc_params.svh"

module wb_reg_file
   import wisc_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  word_t    wb_rd_data_1,
   input  logic     wb_wr_en,
   input  reg_idx_t wb_wr_reg,
   input  wb_sel_t  wb_wr_sel,
   input  word_t    wb_alu_out,
   input  word_t    wb_mem_out,
   input  word_t    wb_pc_inc,
   input  word_t    wb_lbi,
   input  word_t    wb_slbi,
   input  word_t    wb_sext_imm,
   input  logic     wb_set,
   input  reg_idx_t rd_reg_1,
   input  reg_idx_t rd_reg_2,
   output word_t    rd_val_1,
   output word_t    rd_val_2
);

   word_t regs [`REG_NUM];
   word_t wr_val;

   always_comb begin
      case (wb_wr_sel)
         `WB_ALU:    wr_val = wb_alu_out;
         `WB_MEM:    wr_val = wb_mem_out;
         `WB_PC_INC: wr_val = wb_pc_inc;
         `WB_LBI:    wr_val = wb_lbi;
         `WB_SLBI:   wr_val = wb_slbi;
         `WB_SEXT:   wr_val = wb_sext_imm;
         `WB_SET:    wr_val = {{(`WORD_W-1){1'b0}}, wb_set};  // flag as 0 or 1.
         default:    wr_val = wb_rd_data_1;                   // WB_RD1.
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `REG_NUM; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_wr_en) begin
         regs[wb_wr_reg] <= wr_val;
      end
   end

   // same-cycle write is forwarded to the readers.
   assign rd_val_1 = (wb_wr_en && rd_reg_1 == wb_wr_reg) ? wr_val : regs[rd_reg_1];
   assign rd_val_2 = (wb_wr_en && rd_reg_2 == wb_wr_reg) ? wr_val : regs[rd_reg_2];

   // loads must land in the file with the word that left the memory stage.
   a_mem_source : assert property (
      @(posedge clk) disable iff (reset)
      (wb_wr_en && wb_wr_sel == `WB_MEM) |=> (regs[$past(wb_wr_reg)] == $past(wb_mem_out))
   ) else $error("wb_reg_file: load result not written from memory source");

   a_set_source : assert property (
      @(posedge clk) disable iff (reset)
      (wb_wr_en && wb_wr_sel == `WB_SET) |=> (regs[$past(wb_wr_reg)] == word_t'($past(wb_set)))
   ) else $error("wb_reg_file: set flag not written zero-extended");

endmodule

// ==== src/wisc_mem_wb_top.sv ====
`timescale 1ns/1ns

module wisc_mem_wb_top
   import wisc_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     stall_n,
   input  word_t    rd_data_1,
   input  word_t    rd_data_2,
   input  word_t    alu_out,
   input  logic     mem_rd_en,
   input  logic     mem_wr_en,
   input  logic     wr_en,
   input  reg_idx_t wr_reg,
   input  wb_sel_t  wr_sel,
   input  word_t    pc_inc,
   input  word_t    lbi,
   input  word_t    slbi,
   input  word_t    sext_imm,
   input  logic     set,
   input  reg_idx_t rd_reg_1,
   input  reg_idx_t rd_reg_2,
   output word_t    rd_val_1,
   output word_t    rd_val_2,
   output logic     err
);

   word_t    mem_out;
   logic     align_err;

   word_t    wb_rd_data_1;
   logic     wb_wr_en;
   reg_idx_t wb_wr_reg;
   wb_sel_t  wb_wr_sel;
   word_t    wb_alu_out;
   word_t    wb_mem_out;
   word_t    wb_pc_inc;
   word_t    wb_lbi;
   word_t    wb_slbi;
   word_t    wb_sext_imm;
   logic     wb_set;
   logic     wb_err;

   data_mem dmem0 (
      .clk       (clk),
      .reset     (reset),
      .addr      (alu_out),
      .wr_data   (rd_data_2),    // store data.
      .rd_en     (mem_rd_en),
      .wr_en     (mem_wr_en),
      .stall_n   (stall_n),
      .rd_data   (mem_out),
      .align_err (align_err)
   );

   mem_wb mem_wb0 (
      .clk           (clk),
      .reset         (reset),
      .stall_n       (stall_n),
      .mem_rd_data_1 (rd_data_1),
      .mem_wr_en     (wr_en),
      .mem_wr_reg    (wr_reg),
      .mem_wr_sel    (wr_sel),
      .mem_alu_out   (alu_out),
      .mem_mem_out   (mem_out),
      .mem_pc_inc    (pc_inc),
      .mem_lbi       (lbi),
      .mem_slbi      (slbi),
      .mem_sext_imm  (sext_imm),
      .mem_set       (set),
      .mem_err       (align_err),
      .wb_rd_data_1  (wb_rd_data_1),
      .wb_wr_en      (wb_wr_en),
      .wb_wr_reg     (wb_wr_reg),
      .wb_wr_sel     (wb_wr_sel),
      .wb_alu_out    (wb_alu_out),
      .wb_mem_out    (wb_mem_out),
      .wb_pc_inc     (wb_pc_inc),
      .wb_lbi        (wb_lbi),
      .wb_slbi       (wb_slbi),
      .wb_sext_imm   (wb_sext_imm),
      .wb_set        (wb_set),
      .wb_err        (wb_err)
   );

   wb_reg_file rf0 (
      .clk          (clk),
      .reset        (reset),
      .wb_rd_data_1 (wb_rd_data_1),
      .wb_wr_en     (wb_wr_en),
      .wb_wr_reg    (wb_wr_reg),
      .wb_wr_sel    (wb_wr_sel),
      .wb_alu_out   (wb_alu_out),
      .wb_mem_out   (wb_mem_out),
      .wb_pc_inc    (wb_pc_inc),
      .wb_lbi       (wb_lbi),
      .wb_slbi      (wb_slbi),
      .wb_sext_imm  (wb_sext_imm),
      .wb_set       (wb_set),
      .rd_reg_1     (rd_reg_1),
      .rd_reg_2     (rd_reg_2),
      .rd_val_1     (rd_val_1),
      .rd_val_2     (rd_val_2)
   );

   assign err = wb_err;          // misaligned access, one cycle late.

endmodule

// ==== sim/tb_wisc_mem_wb.sv ====
`timescale 1ns/1ns

module tb_wisc_mem_wb
   import wisc_pkg::*;
();

   localparam int    PERIOD      = 100;
   localparam int    MAX_LINES   = 64;
   localparam int    NUM_FIELDS  = 19;
   localparam int    SLACK_CYC   = 12;             // reset plus margin.
   localparam string GOLDEN_PATH = "sim/wisc_mem_wb_golden.txt";

   // column positions in a golden line, after the test name.
   localparam int F_STALL = 0,  F_RD1  = 1,  F_RD2  = 2,  F_ALU   = 3;
   localparam int F_MRD   = 4,  F_MWR  = 5,  F_WREN = 6,  F_WREG  = 7;
   localparam int F_WSEL  = 8,  F_PC   = 9,  F_LBI  = 10, F_SLBI  = 11;
   localparam int F_SEXT  = 12, F_SET  = 13, F_RR1  = 14, F_RR2   = 15;
   localparam int F_EXP1  = 16, F_EXP2 = 17, F_ERR  = 18;

   logic     clk, reset, stall_n;
   word_t    rd_data_1, rd_data_2, alu_out;
   logic     mem_rd_en, mem_wr_en, wr_en, set;
   reg_idx_t wr_reg, rd_reg_1, rd_reg_2;
   wb_sel_t  wr_sel;
   word_t    pc_inc, lbi, slbi, sext_imm;
   word_t    rd_val_1, rd_val_2;
   logic     err;

   string       names [MAX_LINES];
   logic [15:0] rows  [MAX_LINES][NUM_FIELDS];
   int          num_lines   = 0;
   bit          loaded      = 1'b0;
   int          error_count = 0;
   int          check_count = 0;
   int          test_count  = 0;
   int          test_checks = 0;
   int          test_errors = 0;
   string       cur_test    = "";

   wisc_mem_wb_top dut0 (
      .clk (clk), .reset (reset), .stall_n (stall_n),
      .rd_data_1 (rd_data_1), .rd_data_2 (rd_data_2), .alu_out (alu_out),
      .mem_rd_en (mem_rd_en), .mem_wr_en (mem_wr_en),
      .wr_en (wr_en), .wr_reg (wr_reg), .wr_sel (wr_sel),
      .pc_inc (pc_inc), .lbi (lbi), .slbi (slbi), .sext_imm (sext_imm), .set (set),
      .rd_reg_1 (rd_reg_1), .rd_reg_2 (rd_reg_2),
      .rd_val_1 (rd_val_1), .rd_val_2 (rd_val_2), .err (err)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   function automatic int first_space(input string s);
      for (int i = 0; i < s.len(); i++) begin
         if (s.getc(i) == " ") return i;
      end
      return s.len();
   endfunction

   task automatic load_golden();
      int          fd;
      int          got;
      int          sp;
      string       line;
      logic [15:0] f [NUM_FIELDS];
      fd = $fopen(GOLDEN_PATH, "r");
      if (fd == 0) begin
         $display("ERROR: could not open golden file %s", GOLDEN_PATH);
         error_count++;
      end else begin
         while (!$feof(fd) && num_lines < MAX_LINES) begin
            line = "";
            got  = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
               sp = first_space(line);
               got = $sscanf(line.substr(sp + 1, line.len() - 1),
                  "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                  f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
               if (got != NUM_FIELDS) begin
                  $display("ERROR: malformed golden line: %s", line);
                  error_count++;
               end else begin
                  names[num_lines] = line.substr(0, sp - 1);
                  for (int k = 0; k < NUM_FIELDS; k++) rows[num_lines][k] = f[k];
                  num_lines++;
               end
            end
         end
         $fclose(fd);
         if (num_lines == 0) begin
            $display("ERROR: golden file holds no test lines");
            error_count++;
         end
      end
      loaded = 1'b1;
   endtask

   task automatic init_inputs();
      reset     = 1'b1;
      stall_n   = 1'b1;
      rd_data_1 = '0;
      rd_data_2 = '0;
      alu_out   = '0;
      mem_rd_en = 1'b0;
      mem_wr_en = 1'b0;
      wr_en     = 1'b0;
      wr_reg    = '0;
      wr_sel    = '0;
      pc_inc    = '0;
      lbi       = '0;
      slbi      = '0;
      sext_imm  = '0;
      set       = 1'b0;
      rd_reg_1  = '0;
      rd_reg_2  = '0;
   endtask

   task automatic apply_row(input int n);
      stall_n   = rows[n][F_STALL][0];
      rd_data_1 = rows[n][F_RD1];
      rd_data_2 = rows[n][F_RD2];
      alu_out   = rows[n][F_ALU];
      mem_rd_en = rows[n][F_MRD][0];
      mem_wr_en = rows[n][F_MWR][0];
      wr_en     = rows[n][F_WREN][0];
      wr_reg    = rows[n][F_WREG][2:0];
      wr_sel    = rows[n][F_WSEL][2:0];
      pc_inc    = rows[n][F_PC];
      lbi       = rows[n][F_LBI];
      slbi      = rows[n][F_SLBI];
      sext_imm  = rows[n][F_SEXT];
      set       = rows[n][F_SET][0];
      rd_reg_1  = rows[n][F_RR1][2:0];
      rd_reg_2  = rows[n][F_RR2][2:0];
   endtask

   task automatic report_test();
      test_count++;
      $display("test %s: %0d checks, %0d errors, %s", cur_test, test_checks, test_errors,
               (test_errors == 0) ? "ok" : "FAILED");
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic check_value(input string what, input word_t expected, input word_t actual);
      check_count++;
      test_checks++;
      assert (actual == expected) else begin
         $display("MISMATCH %s %s expected %h actual %h", cur_test, what, expected, actual);
         error_count++;
         test_errors++;
      end
   endtask

   initial begin
      init_inputs();
      load_golden();
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (int n = 0; n < num_lines; n++) begin
         if (names[n] != cur_test) begin
            if (n > 0) report_test();
            cur_test = names[n];
         end
         apply_row(n);
         @(posedge clk);
         #(PERIOD/2 - 5);                              // settled, before next drive.
         check_value("rd_val_1", rows[n][F_EXP1], rd_val_1);
         check_value("rd_val_2", rows[n][F_EXP2], rd_val_2);
         check_value("err", word_t'(rows[n][F_ERR][0]), word_t'(err));
         @(negedge clk);
      end
      if (num_lines > 0) report_test();
      $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   initial begin
      int limit_ns;
      wait (loaded);
      limit_ns = (num_lines + SLACK_CYC) * PERIOD;
      #(limit_ns);
      $display("ERROR: watchdog expired after %0d ns, run did not complete", limit_ns);
      $display("Testbench failed");
      $finish;
   end

endmodule

// ==== sim/wisc_mem_wb_golden.txt ====
# name stall rd_data_1 rd_data_2 alu_out mem_rd mem_wr wr_en wr_reg wr_sel pc_inc lbi slbi
# sext_imm set rd_reg_1 rd_reg_2 exp_rd_val_1 exp_rd_val_2 exp_err (hex, one cycle per line)
reset_zero 1 0000 0000 0000 0 0 0 0 0 0000 0000 0000 0000 0 0 1 0000 0000 0
reset_zero 1 0000 0000 0000 0 0 0 0 0 0000 0000 0000 0000 0 2 3 0000 0000 0
reset_zero 1 0000 0000 0000 0 0 0 0 0 0000 0000 0000 0000 0 4 5 0000 0000 0
reset_zero 1 0000 0000 0000 0 0 0 0 0 0000 0000 0000 0000 0 6 7 0000 0000 0
wb_select 1 0000 beef 0040 0 1 0 0 0 0000 0000 0000 0000 0 0 1 0000 0000 0
wb_select 1 7777 0000 0040 0 0 1 0 0 2222 3333 4444 5555 1 0 7 0040 0000 0
wb_select 1 7777 0000 0040 0 0 1 1 1 2222 3333 4444 5555 1 1 0 beef 0040 0
wb_select 1 7777 0000 0040 0 0 1 2 2 2222 3333 4444 5555 1 2 1 2222 beef 0
wb_select 1 7777 0000 0040 0 0 1 3 3 2222 3333 4444 5555 1 3 2 3333 2222 0
wb_select 1 7777 0000 0040 0 0 1 4 4 2222 3333 4444 5555 1 4 3 4444 3333 0
wb_select 1 7777 0000 0040 0 0 1 5 5 2222 3333 4444 5555 1 5 4 5555 4444 0
wb_select 1 7777 0000 0040 0 0 1 6 6 2222 3333 4444 5555 1 6 5 0001 5555 0
wb_select 1 7777 0000 0040 0 0 1 7 7 2222 3333 4444 5555 1 7 6 7777 0001 0
wb_select 1 0000 0000 0000 0 0 0 0 0 0000 0000 0000 0000 0 7 0 7777 0040 0
wb_select 1 0000 0000 0000 0 0 0 0 0 0000 0000 0000 0000 0 1 3 beef 3333 0
store_load 1 0000 cafe 0010 0 1 0 0 0 0000 0000 0000 0000 0 2 0 2222 0040 0
store_load 1 0000 0000 0010 1 0 1 2 1 0000 0000 0000 0000 0 2 1 cafe beef 0
store_load 1 0000 0000 0000 0 0 0 0 0 0000 0000 0000 0000 0 2 3 cafe 3333 0
stall 0 0000 0000 1234 0 0 1 3 0 0000 0000 0000 0000 0 3 3 3333 3333 0
stall 0 0000 0000 1234 0 0 1 3 0 0000 0000 0000 0000 0 3 3 3333 3333 0
stall 1 0000 0000 1234 0 0 1 3 0 0000 0000 0000 0000 0 3 3 1234 1234 0
stall 1 0000 0000 0000 0 0 0 0 0 0000 0000 0000 0000 0 3 2 1234 cafe 0
bypass 1 0000 0000 0000 0 0 1 4 3 0000 0abc 0000 0000 0 4 4 0abc 0abc 0
bypass 1 0000 0000 0000 0 0 1 4 3 0000 0def 0000 0000 0 4 5 0def 5555 0
bypass 1 0000 0000 0000 0 0 0 0 0 0000 0000 0000 0000 0 4 0 0def 0040 0
misalign 1 0000 dead 0011 0 1 0 0 0 0000 0000 0000 0000 0 2 0 cafe 0040 1
misalign 1 0000 0000 0000 0 0 0 0 0 0000 0000 0000 0000 0 2 0 cafe 0040 0
misalign 1 0000 0000 0010 1 0 1 5 1 0000 0000 0000 0000 0 5 6 cafe 0001 0
misalign 1 0000 0000 0012 1 0 1 6 1 0000 0000 0000 0000 0 6 5 0000 cafe 0
misalign 1 0000 0000 0000 0 0 0 0 0 0000 0000 0000 0000 0 5 6 cafe 0000 0

// ==== wisc_mem_wb.f ====
+incdir+src
src/wisc_pkg.sv
src/data_mem.sv
src/mem_wb.sv
src/wb_reg_file.sv
src/wisc_mem_wb_top.sv
sim/tb_wisc_mem_wb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the wisc_mem_wb testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_wisc_mem_wb -f wisc_mem_wb.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_wisc_mem_wb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
   exit 0
fi
exit 1
